// File: Bender.yml
package:
  name: async_fifo

sources:
  # RTL in compile order.
  - rtl/async_fifo_pkg.sv
  - rtl/dualport_ram_async.sv
  - rtl/gray_sync.sv
  - rtl/fifo_wr_ctrl.sv
  - rtl/fifo_rd_ctrl.sv
  - rtl/async_fifo.sv

  # Testbench sources.
  - target: test
    files:
      - testbench/async_fifo_props.sv
      - testbench/async_fifo_tb.sv

// File: project.f
rtl/async_fifo_pkg.sv
rtl/dualport_ram_async.sv
rtl/gray_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
testbench/async_fifo_props.sv
testbench/async_fifo_tb.sv

// File: rtl/async_fifo.sv
`timescale 1ns/1ps

module async_fifo (
  input  logic                                  wr_clk,
  input  logic                                  rd_clk,
  input  logic                                  reset,
  input  logic                                  wr_en,
  input  logic                                  rd_en,
  input  logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data,
  output logic [async_fifo_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                                  full,
  output logic                                  afull,
  output logic                                  empty,
  output logic                                  aempty
);

  import async_fifo_pkg::*;

  logic                  wr_accept;
  logic                  rd_accept;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [PTR_WIDTH-1:0]  wr_ptr_gray;
  logic [PTR_WIDTH-1:0]  rd_ptr_gray;
  logic [PTR_WIDTH-1:0]  wr_ptr_bin_rsync;  // Write pointer in rd_clk domain.
  logic [PTR_WIDTH-1:0]  rd_ptr_bin_wsync;  // Read pointer in wr_clk domain.

  dualport_ram_async i_ram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .reset     (reset),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  fifo_wr_ctrl i_wr_ctrl (
    .wr_clk           (wr_clk),
    .reset            (reset),
    .wr_en            (wr_en),
    .rd_ptr_bin_wsync (rd_ptr_bin_wsync),
    .wr_accept        (wr_accept),
    .wr_addr          (wr_addr),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  fifo_rd_ctrl i_rd_ctrl (
    .rd_clk           (rd_clk),
    .reset            (reset),
    .rd_en            (rd_en),
    .wr_ptr_bin_rsync (wr_ptr_bin_rsync),
    .rd_accept        (rd_accept),
    .rd_addr          (rd_addr),
    .rd_ptr_gray      (rd_ptr_gray),
    .empty            (empty),
    .aempty           (aempty)
  );

  // Write pointer into the read domain.
  gray_sync i_wr_to_rd (
    .clk      (rd_clk),
    .reset    (reset),
    .ptr_gray (wr_ptr_gray),
    .ptr_bin  (wr_ptr_bin_rsync)
  );

  // Read pointer into the write domain.
  gray_sync i_rd_to_wr (
    .clk      (wr_clk),
    .reset    (reset),
    .ptr_gray (rd_ptr_gray),
    .ptr_bin  (rd_ptr_bin_wsync)
  );

endmodule

// File: rtl/async_fifo_pkg.sv
package async_fifo_pkg;

  // Payload word.
  localparam int DATA_WIDTH = 8;

  // Number of words held, a power of two.
  localparam int FIFO_DEPTH = 16;

  // RAM address bits.
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Pointers carry one extra wrap bit so that full and empty differ.
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // Flag thresholds, in words used.
  localparam int FIFO_AFULL  = FIFO_DEPTH - 1;
  localparam int FIFO_AEMPTY = 1;

endpackage

// File: rtl/dualport_ram_async.sv
`timescale 1ns/1ps

module dualport_ram_async (
  input  logic                                  wr_clk,
  input  logic                                  wr_accept,
  input  logic [async_fifo_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                                  rd_clk,
  input  logic                                  reset,
  input  logic                                  rd_accept,
  input  logic [async_fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [async_fifo_pkg::DATA_WIDTH-1:0] rd_data
);

  import async_fifo_pkg::*;

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Write port, wr_clk domain.
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port with output register, rd_clk domain.
  // Holds the last word until the next accepted read.
  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: rtl/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl (
  input  logic                                  rd_clk,
  input  logic                                  reset,
  input  logic                                  rd_en,
  input  logic [async_fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_bin_rsync,
  output logic                                  rd_accept,
  output logic [async_fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [async_fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray,
  output logic                                  empty,
  output logic                                  aempty
);

  import async_fifo_pkg::*;

  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr_nxt;
  logic [PTR_WIDTH-1:0] rd_gray_nxt;
  logic [PTR_WIDTH-1:0] rd_used_nxt;
  logic                 empty_nxt;
  logic                 aempty_nxt;

  // Reads from an empty FIFO are ignored.
  assign rd_accept = rd_en && !empty;

  assign rd_ptr_nxt  = rd_ptr + PTR_WIDTH'(rd_accept);
  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);
  assign rd_addr     = rd_ptr[ADDR_WIDTH-1:0];

  // Synchronized write pointer lags, so the count errs low.
  assign rd_used_nxt = wr_ptr_bin_rsync - rd_ptr_nxt;

  assign empty_nxt  = (rd_used_nxt == '0);
  assign aempty_nxt = (rd_used_nxt <= PTR_WIDTH'(FIFO_AEMPTY));

  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      empty       <= 1'b1;  // Nothing stored yet.
      aempty      <= 1'b1;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
      empty       <= empty_nxt;
      aempty      <= aempty_nxt;
    end
  end

endmodule

// File: rtl/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl (
  input  logic                                  wr_clk,
  input  logic                                  reset,
  input  logic                                  wr_en,
  input  logic [async_fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_bin_wsync,
  output logic                                  wr_accept,
  output logic [async_fifo_pkg::ADDR_WIDTH-1:0] wr_addr,
  output logic [async_fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray,
  output logic                                  full,
  output logic                                  afull
);

  import async_fifo_pkg::*;

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr_nxt;
  logic [PTR_WIDTH-1:0] wr_gray_nxt;
  logic [PTR_WIDTH-1:0] wr_used_nxt;
  logic                 full_nxt;
  logic                 afull_nxt;

  // Writes into a full FIFO are dropped.
  assign wr_accept = wr_en && !full;

  assign wr_ptr_nxt  = wr_ptr + PTR_WIDTH'(wr_accept);
  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);
  assign wr_addr     = wr_ptr[ADDR_WIDTH-1:0];

  // Used words seen from the write side, modulo 2**PTR_WIDTH.
  // The synchronized read pointer lags, so this count is never too low.
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_bin_wsync;

  assign full_nxt  = (wr_used_nxt == PTR_WIDTH'(FIFO_DEPTH));
  assign afull_nxt = (wr_used_nxt >= PTR_WIDTH'(FIFO_AFULL));

  always_ff @(posedge wr_clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;  // Glitch free toward rd_clk.
      full        <= full_nxt;
      afull       <= afull_nxt;
    end
  end

endmodule

// File: rtl/gray_sync.sv
`timescale 1ns/1ps

module gray_sync (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [async_fifo_pkg::PTR_WIDTH-1:0] ptr_gray,
  output logic [async_fifo_pkg::PTR_WIDTH-1:0] ptr_bin
);

  import async_fifo_pkg::*;

  logic [PTR_WIDTH-1:0] sync_q1;  // May go metastable.
  logic [PTR_WIDTH-1:0] sync_q2;

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray;
      sync_q2 <= sync_q1;
    end
  end

  // Gray to binary.
  // Each bit is the XOR of itself and all higher bits.
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      ptr_bin[i] = ^(sync_q2 >> i);
    end
  end

endmodule

// File: testbench/async_fifo_props.sv
`timescale 1ns/1ps

module async_fifo_props (
  input logic                                 wr_clk,
  input logic                                 rd_clk,
  input logic                                 reset,
  input logic                                 wr_accept,
  input logic                                 full,
  input logic                                 afull,
  input logic                                 empty,
  input logic                                 aempty,
  input logic [async_fifo_pkg::PTR_WIDTH-1:0] wr_ptr_gray,
  input logic [async_fifo_pkg::PTR_WIDTH-1:0] rd_ptr_gray
);

  int fail_count = 0;  // Failed assertions so far.

  full_has_afull: assert property (@(posedge wr_clk) disable iff (reset) full |-> afull)
    else begin
      $error("full is high while afull is low");
      fail_count++;
    end

  empty_has_aempty: assert property (@(posedge rd_clk) disable iff (reset) empty |-> aempty)
    else begin
      $error("empty is high while aempty is low");
      fail_count++;
    end

  no_write_when_full: assert property (@(posedge wr_clk) disable iff (reset)
    !(wr_accept && full))
    else begin
      $error("a write was accepted while full");
      fail_count++;
    end

  // Gray pointers change one bit at a time.
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (reset)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
    else begin
      $error("wr_ptr_gray changed more than one bit");
      fail_count++;
    end

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (reset)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1)
    else begin
      $error("rd_ptr_gray changed more than one bit");
      fail_count++;
    end

  flags_after_reset: assert property (@(posedge rd_clk) $fell(reset) |-> empty && aempty)
    else begin
      $error("empty or aempty low in the first cycle after reset");
      fail_count++;
    end

endmodule

bind async_fifo async_fifo_props i_props (
  .wr_clk      (wr_clk),
  .rd_clk      (rd_clk),
  .reset       (reset),
  .wr_accept   (wr_accept),
  .full        (full),
  .afull       (afull),
  .empty       (empty),
  .aempty      (aempty),
  .wr_ptr_gray (wr_ptr_gray),
  .rd_ptr_gray (rd_ptr_gray)
);

// File: testbench/async_fifo_tb.sv
`timescale 1ns/1ps

module async_fifo_tb;

  import async_fifo_pkg::*;

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  reset;
  logic                  wr_en;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  logic [DATA_WIDTH-1:0] ref_q[$];  // Words the DUT holds, oldest first.
  logic [DATA_WIDTH-1:0] last_read;  // Last word the model handed out.
  logic [15:0]           lfsr_state;
  int                    errors;

  async_fifo i_dut (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .full    (full),
    .afull   (afull),
    .empty   (empty),
    .aempty  (aempty)
  );

  always #5 wr_clk = ~wr_clk;
  always #7 rd_clk = ~rd_clk;  // Unrelated to wr_clk.

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic logic next_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] random_word();
    logic [DATA_WIDTH-1:0] word;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      word[i] = next_bit();
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    assert (actual === expected)
    else begin
      $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t: %s", $time, what);
    errors++;
  endtask

  // Model takes the word only if full was low at the accepting edge.
  task automatic push_word(input logic [DATA_WIDTH-1:0] data);
    @(posedge wr_clk);
    #1;
    wr_en   = 1'b1;
    wr_data = data;
    if (!full) begin
      ref_q.push_back(data);
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic check_read_word();
    if (ref_q.size() == 0) begin
      report_failure("DUT returned a word while the reference queue was empty");
    end else begin
      last_read = ref_q.pop_front();
      check_value("rd_data", last_read, rd_data);
    end
  endtask

  // rd_data is due one rd_clk after the accepting edge.
  task automatic pop_word(output logic accepted);
    @(posedge rd_clk);
    #1;
    rd_en    = 1'b1;
    accepted = !empty;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
    if (accepted) begin
      check_read_word();
    end
  endtask

  task automatic read_and_check();
    logic accepted;
    int   tries;
    accepted = 1'b0;
    tries    = 0;
    while (!accepted && tries < 50) begin
      pop_word(accepted);
      tries++;
    end
    if (!accepted) begin
      report_failure("no read was accepted within 50 attempts, empty stayed high");
    end
  endtask

  task automatic wait_read_flag(input string name, input logic level);
    int   cycles;
    logic flag;
    cycles = 0;
    do begin
      @(posedge rd_clk);
      #1;
      flag = (name == "aempty") ? aempty : empty;
      cycles++;
    end while (flag !== level && cycles < 50);
    if (flag !== level) begin
      report_failure($sformatf("%s did not reach %0b within 50 rd_clk cycles", name, level));
    end
  endtask

  task automatic wait_write_flag(input string name, input logic level);
    int   cycles;
    logic flag;
    cycles = 0;
    do begin
      @(posedge wr_clk);
      #1;
      flag = (name == "afull") ? afull : full;
      cycles++;
    end while (flag !== level && cycles < 50);
    if (flag !== level) begin
      report_failure($sformatf("%s did not reach %0b within 50 wr_clk cycles", name, level));
    end
  endtask

  task automatic test_reset_state();
    @(posedge rd_clk);
    #1;
    check_value("empty", 1'b1, empty);
    check_value("aempty", 1'b1, aempty);
    check_value("rd_data", '0, rd_data);
    @(posedge wr_clk);
    #1;
    check_value("full", 1'b0, full);
    check_value("afull", 1'b0, afull);
  endtask

  task automatic test_order();
    repeat (10) begin
      push_word(random_word());
    end
    wait_read_flag("empty", 1'b0);
    repeat (10) begin
      read_and_check();
    end
  endtask

  task automatic test_fill_full();
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      push_word(random_word());
      if (i == FIFO_AFULL - 2) begin
        check_value("afull", 1'b0, afull);
      end
      if (i == FIFO_AFULL - 1) begin
        check_value("afull", 1'b1, afull);
        check_value("full", 1'b0, full);
      end
    end
    check_value("full", 1'b1, full);
    check_value("afull", 1'b1, afull);
    push_word(8'ha5);  // Must be dropped.
    check_value("full", 1'b1, full);
    wait_read_flag("empty", 1'b0);
    repeat (FIFO_DEPTH) begin
      read_and_check();
    end
    check_value("empty", 1'b1, empty);
    wait_write_flag("full", 1'b0);
  endtask

  task automatic test_read_empty();
    @(posedge rd_clk);
    #1;
    check_value("empty", 1'b1, empty);
    check_value("rd_data", last_read, rd_data);
    rd_en = 1'b1;
    repeat (3) @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
    @(posedge rd_clk);
    #1;
    check_value("rd_data", last_read, rd_data);
    check_value("empty", 1'b1, empty);
    push_word(random_word());
    read_and_check();
  endtask

  task automatic test_thresholds();
    repeat (3) begin
      push_word(random_word());
    end
    wait_read_flag("aempty", 1'b0);
    check_value("empty", 1'b0, empty);
    repeat (2) begin
      read_and_check();
    end
    wait_read_flag("aempty", 1'b1);
    check_value("empty", 1'b0, empty);
    read_and_check();
    check_value("empty", 1'b1, empty);
  endtask

  // Enables and data are drawn up front, then both domains run in parallel.
  task automatic test_mixed_traffic();
    logic                  wr_bits[300];
    logic                  rd_bits[220];
    logic [DATA_WIDTH-1:0] words[300];
    logic                  read_pending;
    logic                  accepted;
    logic                  bit_a;
    logic                  bit_b;
    int                    guard;
    for (int i = 0; i < 300; i++) begin
      words[i]   = random_word();
      wr_bits[i] = next_bit();
    end
    for (int i = 0; i < 220; i++) begin
      bit_a      = next_bit();
      bit_b      = next_bit();
      rd_bits[i] = bit_a | bit_b;  // Reads slightly outpace writes.
    end
    fork
      begin
        for (int i = 0; i < 300; i++) begin
          @(posedge wr_clk);
          #1;
          wr_en   = wr_bits[i];
          wr_data = words[i];
          if (wr_bits[i] && !full) begin
            ref_q.push_back(words[i]);
          end
        end
        @(posedge wr_clk);
        #1;
        wr_en = 1'b0;
      end
      begin
        read_pending = 1'b0;
        for (int i = 0; i < 220; i++) begin
          @(posedge rd_clk);
          #1;
          if (read_pending) begin
            check_read_word();
          end
          rd_en        = rd_bits[i];
          read_pending = rd_bits[i] && !empty;
        end
        @(posedge rd_clk);
        #1;
        rd_en = 1'b0;
        if (read_pending) begin
          check_read_word();
        end
      end
    join
    guard = 0;
    while (ref_q.size() > 0 && guard < 4 * FIFO_DEPTH) begin
      pop_word(accepted);
      guard++;
    end
    if (ref_q.size() > 0) begin
      report_failure("words were still queued after the drain limit in mixed traffic");
    end
    check_value("empty", 1'b1, empty);
  endtask

  initial begin
    wr_clk     = 1'b0;
    rd_clk     = 1'b0;
    reset      = 1'b1;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    wr_data    = '0;
    last_read  = '0;
    errors     = 0;
    lfsr_state = 16'd61;
    repeat (4) @(posedge rd_clk);
    #1;
    reset = 1'b0;

    test_reset_state();
    test_order();
    test_fill_full();
    test_read_empty();
    test_thresholds();
    test_mixed_traffic();

    $display("Errors: %0d in checks, %0d in assertions", errors, i_dut.i_props.fail_count);
    if (errors == 0 && i_dut.i_props.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
